/* Makefile */
TOOL      := verilator
FLAGS     := --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS := --lint-only -Wall --timing
TOP       := tb_hdmi_data_island
FILELIST  := hdmi_data_island.f
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -qF '*** FAILED ***' $(LOG) || ! grep -qF '*** PASSED ***' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; fi

lint:
	$(TOOL) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* common/hdmi_link_pkg.sv */
package hdmi_link_pkg;

    // One packet fills a slot of 32 pixel clocks.
    localparam int slot_cycles = 32;
    localparam int counter_width = $clog2(slot_cycles);

    // Last counter values that still feed message bits into the parity.
    localparam int header_bits_last = 23; // 24 header bits, one per cycle.
    localparam int sub_pairs_last = 27;   // 56 subpacket bits, two per cycle.

    // Widths on the link side.
    localparam int nibble_width = 4;  // TERC4 input per channel.
    localparam int data_width = 9;    // Header bit plus even and odd nibbles.
    localparam int symbol_width = 10; // One TMDS character.

    // TERC4 code words, indexed by the 4-bit nibble.
    localparam logic [symbol_width-1:0] terc4_table [16] = '{
        10'b1010011100, // 0000
        10'b1001100011, // 0001
        10'b1011100100, // 0010
        10'b1011100010, // 0011
        10'b0101110001, // 0100
        10'b0100011110, // 0101
        10'b0110001110, // 0110
        10'b0100111100, // 0111
        10'b1011001100, // 1000
        10'b0100111001, // 1001
        10'b0110011100, // 1010
        10'b1011000110, // 1011
        10'b1010001110, // 1100
        10'b1001110001, // 1101
        10'b0101100011, // 1110
        10'b1011000011  // 1111
    };

endpackage

/* common/hdmi_packet_pkg.sv */
package hdmi_packet_pkg;

    // Every data island packet is one header and four subpackets.
    localparam int header_width = 24; // HB0 to HB2, sent one bit per pixel clock.
    localparam int sub_width = 56;    // SB0 to SB6, sent two bits per pixel clock.
    localparam int sub_count = 4;
    localparam int ecc_width = 8;     // One BCH parity byte closes each block.

    // Generator of the BCH(64,56) and BCH(32,24) codes, in shift-right form.
    localparam logic [ecc_width-1:0] ecc_poly = 8'b1000_0011;

    // Packet type codes that go into HB0.
    localparam logic [7:0] type_null = 8'h00;
    localparam logic [7:0] type_acr = 8'h01;
    localparam logic [7:0] type_avi = 8'h82; // InfoFrame types have bit 7 set.

    // AVI InfoFrame version 2 carries a 13-byte body after the checksum.
    localparam logic [7:0] avi_version = 8'h02;
    localparam logic [7:0] avi_length = 8'h0d;

    // Field widths of the ACR values and the video identification code.
    localparam int acr_field_width = 20;
    localparam int vic_width = 7;

    // One step of the systematic BCH encoder.
    // The message bit enters at the low end and the register shifts right,
    // so after the last message bit the register holds the parity byte.
    function automatic logic [ecc_width-1:0] next_ecc(
        input logic [ecc_width-1:0] ecc,
        input logic                 message_bit
    );
        logic feedback;
        feedback = ecc[0] ^ message_bit; // Bit that leaves the register.
        next_ecc = (ecc >> 1) ^ (feedback ? ecc_poly : '0);
    endfunction

endpackage

/* hdmi_data_island.f */
common/hdmi_packet_pkg.sv
common/hdmi_link_pkg.sv
packet_assembler/packet_assembler.sv
verilog/infoframe_builder.sv
verilog/packet_picker.sv
verilog/terc4_encoder.sv
verilog/hdmi_data_island.sv
testbench/tb_clock_gen.sv
testbench/hdmi_data_island_sva.sv
testbench/tb_hdmi_data_island.sv

/* packet_assembler/packet_assembler.sv */
`timescale 1ns/100ps

module packet_assembler (
    input  logic                                      clk_pixel,
    input  logic                                      rst_n,
    input  logic                                      enable, // Whole 32-cycle slots.
    input  logic [hdmi_packet_pkg::header_width-1:0]  header,
    input  logic [hdmi_packet_pkg::sub_width-1:0]     sub0,
    input  logic [hdmi_packet_pkg::sub_width-1:0]     sub1,
    input  logic [hdmi_packet_pkg::sub_width-1:0]     sub2,
    input  logic [hdmi_packet_pkg::sub_width-1:0]     sub3,
    output logic [hdmi_link_pkg::data_width-1:0]      packet_data,
    output logic                                      packet_first,
    output logic                                      packet_request
);

    logic [hdmi_link_pkg::counter_width-1:0] counter; // Position inside the slot.
    logic [hdmi_packet_pkg::ecc_width-1:0] header_parity;
    logic [hdmi_packet_pkg::ecc_width-1:0] header_parity_next;
    logic [hdmi_packet_pkg::ecc_width-1:0] sub_parity [hdmi_packet_pkg::sub_count];
    logic [hdmi_packet_pkg::ecc_width-1:0] sub_parity_half [hdmi_packet_pkg::sub_count];
    logic [hdmi_packet_pkg::ecc_width-1:0] sub_parity_next [hdmi_packet_pkg::sub_count];
    logic [hdmi_packet_pkg::sub_width-1:0] sub_word [hdmi_packet_pkg::sub_count];
    logic [hdmi_packet_pkg::header_width+hdmi_packet_pkg::ecc_width-1:0] header_block;
    logic [hdmi_packet_pkg::sub_width+hdmi_packet_pkg::ecc_width-1:0]
        sub_block [hdmi_packet_pkg::sub_count];
    logic [hdmi_link_pkg::counter_width:0] even_idx; // Subpacket bits go out in pairs.
    logic [hdmi_link_pkg::counter_width:0] odd_idx;
    logic [hdmi_packet_pkg::sub_count-1:0] even_bits;
    logic [hdmi_packet_pkg::sub_count-1:0] odd_bits;

    assign sub_word[0] = sub0;
    assign sub_word[1] = sub1;
    assign sub_word[2] = sub2;
    assign sub_word[3] = sub3;

    // The parity byte sits right after the message, so the same index walks both.
    assign header_block = {header_parity, header};
    assign even_idx = {counter, 1'b0};
    assign odd_idx = {counter, 1'b1};
    assign header_parity_next = hdmi_packet_pkg::next_ecc(header_parity, header_block[counter]);

    // Two message bits per cycle, so each subpacket parity takes two steps at once.
    always_comb
    begin
        for (int i = 0; i < hdmi_packet_pkg::sub_count; i++)
        begin
            sub_block[i] = {sub_parity[i], sub_word[i]};
            even_bits[i] = sub_block[i][even_idx];
            odd_bits[i] = sub_block[i][odd_idx];
            sub_parity_half[i] = hdmi_packet_pkg::next_ecc(sub_parity[i], even_bits[i]);
            sub_parity_next[i] = hdmi_packet_pkg::next_ecc(sub_parity_half[i], odd_bits[i]);
        end
    end

    // The picker swaps in the next packet at the end of this cycle.
    assign packet_request = enable && counter == hdmi_link_pkg::slot_cycles - 1;

    always_ff @(posedge clk_pixel)
    begin
        if (!rst_n)
        begin
            counter <= '0;
            header_parity <= '0;
            sub_parity <= '{default: '0};
            packet_first <= 1'b0;
        end
        else
        begin
            packet_first <= enable && counter == '0; // Marks slice 0 of each packet.
            if (enable)
            begin
                counter <= counter + 1'b1; // Wraps from 31 back to 0.
                if (counter <= hdmi_link_pkg::header_bits_last)
                    header_parity <= header_parity_next;
                if (counter <= hdmi_link_pkg::sub_pairs_last)
                    sub_parity <= sub_parity_next;
                // Parity bytes have gone out by now, start clean for the next packet.
                if (counter == hdmi_link_pkg::slot_cycles - 1)
                begin
                    header_parity <= '0;
                    sub_parity <= '{default: '0};
                end
            end
        end
    end

    // Slice layout is odd nibble, even nibble, then the header bit in bit 0.
    always_ff @(posedge clk_pixel)
    begin
        if (enable)
            packet_data <= {odd_bits, even_bits, header_block[counter]};
    end

endmodule

/* testbench/hdmi_data_island_sva.sv */
`timescale 1ns/100ps

module hdmi_data_island_sva (
    input logic                                    clk_pixel,
    input logic                                    rst_n,
    input logic                                    enable,
    input logic                                    packet_request,
    input logic [hdmi_link_pkg::counter_width-1:0] counter
);

    // A request may only come from inside an island slot.
    request_needs_enable: assert property (@(posedge clk_pixel) disable iff (!rst_n)
        packet_request |-> enable)
        else $error("packet_request was high while enable was low");

    // Between slots the position inside the packet is frozen.
    counter_holds: assert property (@(posedge clk_pixel) disable iff (!rst_n)
        !enable |=> $stable(counter))
        else $error("counter moved while enable was low");

    // The request marks the last slice, so the next packet starts at slice 0.
    request_wraps: assert property (@(posedge clk_pixel) disable iff (!rst_n)
        packet_request |=> counter == '0)
        else $error("counter did not wrap to 0 after packet_request");

endmodule

/* testbench/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int period_ns = 100,
    parameter int reset_cycles = 10
) (
    output logic clk_pixel,
    output logic rst_n
);

    // Free-running pixel clock, starting low.
    initial
    begin
        clk_pixel = 1'b0;
        forever
            #(period_ns / 2) clk_pixel = ~clk_pixel;
    end

    // Reset is held over the first rising edges and released on a falling edge.
    initial
    begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk_pixel);
        @(negedge clk_pixel);
        rst_n = 1'b1;
    end

endmodule

/* testbench/tb_hdmi_data_island.sv */
`timescale 1ns/100ps

module tb_hdmi_data_island;

    localparam int period_ns = 100;
    localparam int reset_cycles = 10;
    localparam int slot_total = 80;   // Packet slots driven in one run.
    localparam int gap_max = 7;       // Longest idle gap after a slot.
    localparam int margin_cycles = 200;
    localparam int watchdog_ns =
        (reset_cycles + slot_total * (hdmi_link_pkg::slot_cycles + gap_max) + margin_cycles)
        * period_ns;

    typedef logic [hdmi_link_pkg::symbol_width-1:0] symbol_t;
    typedef logic [hdmi_packet_pkg::header_width-1:0] header_t;
    typedef logic [hdmi_packet_pkg::sub_width-1:0] sub_t;
    typedef logic [hdmi_packet_pkg::ecc_width-1:0] ecc_t;

    logic clk_pixel;
    logic rst_n;
    logic island_active;
    logic hsync;
    logic vsync;
    logic acr_strobe;
    logic [hdmi_packet_pkg::acr_field_width-1:0] acr_n;
    logic [hdmi_packet_pkg::acr_field_width-1:0] acr_cts;
    logic [hdmi_packet_pkg::vic_width-1:0] video_code;
    symbol_t tmds_ch0;
    symbol_t tmds_ch1;
    symbol_t tmds_ch2;

    integer seed = 32'hc25b;
    int slots_started;
    int slot_left;   // Cycles still to go in the current slot.
    int gap_left;    // Idle cycles before the next slot may start.
    int checked_slots;
    int acr_seen;
    int avi_seen;
    int null_seen;

    // Reference state, one step per rising edge of the DUT.
    logic [hdmi_link_pkg::counter_width-1:0] m_counter;
    logic m_acr_pending;
    logic m_avi_pending;
    logic m_vsync_prev;
    logic [hdmi_packet_pkg::acr_field_width-1:0] m_n;
    logic [hdmi_packet_pkg::acr_field_width-1:0] m_cts;
    logic [hdmi_packet_pkg::vic_width-1:0] m_vic;
    header_t m_header;
    sub_t m_sub [hdmi_packet_pkg::sub_count];

    // Inputs of the last two cycles; symbols trail them by two clocks.
    logic h0_active;
    logic h1_active;
    logic [hdmi_link_pkg::counter_width-1:0] h0_k;
    logic [hdmi_link_pkg::counter_width-1:0] h1_k;
    logic h0_hs;
    logic h1_hs;
    logic h0_vs;
    logic h1_vs;

    // Packet of the slot under check and the bits that came back from the link.
    header_t chk_header;
    sub_t chk_sub [hdmi_packet_pkg::sub_count];
    logic [31:0] rx_hblock;
    logic [63:0] rx_sblock [hdmi_packet_pkg::sub_count];

    tb_clock_gen #(.period_ns(period_ns), .reset_cycles(reset_cycles)) u_clock (
        .clk_pixel(clk_pixel),
        .rst_n(rst_n)
    );

    hdmi_data_island uut (
        .clk_pixel(clk_pixel), .rst_n(rst_n), .island_active(island_active),
        .hsync(hsync), .vsync(vsync), .acr_strobe(acr_strobe),
        .acr_n(acr_n), .acr_cts(acr_cts), .video_code(video_code),
        .tmds_ch0(tmds_ch0), .tmds_ch1(tmds_ch1), .tmds_ch2(tmds_ch2)
    );

    bind packet_assembler hdmi_data_island_sva u_sva (
        .clk_pixel(clk_pixel), .rst_n(rst_n), .enable(enable),
        .packet_request(packet_request), .counter(counter)
    );

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("*** FAILED ***");
        $fatal(1, "Run stopped at the first error.");
    endtask

    task automatic compare_symbol(input string name, input symbol_t got, input symbol_t exp);
        if (got !== exp)
            fail_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic compare_header(input string name, input header_t got, input header_t exp);
        if (got !== exp)
            fail_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic compare_sub(input string name, input sub_t got, input sub_t exp);
        if (got !== exp)
            fail_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic compare_byte(input string name, input ecc_t got, input ecc_t exp);
        if (got !== exp)
            fail_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    // BCH parity over the first count bits, lowest bit first.
    function automatic ecc_t parity_of(input logic [55:0] bits, input int count);
        ecc_t ecc;
        ecc = '0;
        for (int b = 0; b < count; b++)
            ecc = hdmi_packet_pkg::next_ecc(ecc, bits[b]);
        return ecc;
    endfunction

    // Valid flag in bit 4 and the nibble below it.
    function automatic logic [4:0] decode_terc4(input symbol_t symbol);
        logic [4:0] result;
        result = '0;
        for (int v = 0; v < 16; v++)
            if (hdmi_link_pkg::terc4_table[v] === symbol)
                result = {1'b1, 4'(v)};
        return result;
    endfunction

    // Byte 0 goes out first, so it sits at the low end of the word.
    function automatic sub_t pack_bytes(input logic [7:0] sb [7]);
        sub_t word;
        for (int i = 0; i < 7; i++)
            word[8*i +: 8] = sb[i];
        return word;
    endfunction

    function automatic sub_t acr_body(input logic [19:0] n, input logic [19:0] cts);
        logic [7:0] sb [7];
        sb[0] = 8'h00;
        sb[1] = {4'h0, cts[19:16]}; // CTS, most significant part first.
        sb[2] = cts[15:8];
        sb[3] = cts[7:0];
        sb[4] = {4'h0, n[19:16]};   // Then N in the same order.
        sb[5] = n[15:8];
        sb[6] = n[7:0];
        return pack_bytes(sb);
    endfunction

    function automatic sub_t avi_body(input logic [6:0] vic);
        logic [7:0] pb [7];
        logic [7:0] sum;
        pb = '{default: 8'h00}; // RGB, no bars, no scan info.
        pb[2] = 8'h08;          // Active format same as the picture.
        pb[4] = {1'b0, vic};
        sum = hdmi_packet_pkg::type_avi + hdmi_packet_pkg::avi_version
            + hdmi_packet_pkg::avi_length;
        for (int i = 1; i < 7; i++)
            sum = sum + pb[i];
        pb[0] = 8'h00 - sum;    // Checksum brings the total to zero.
        return pack_bytes(pb);
    endfunction

    task automatic model_step();
        logic request;
        logic load_acr;
        logic load_avi;
        request = island_active && m_counter == 5'(hdmi_link_pkg::slot_cycles - 1);
        load_acr = request && m_acr_pending;
        load_avi = request && !m_acr_pending && m_avi_pending; // ACR goes first.
        if (load_acr)
            m_header = {16'h0000, hdmi_packet_pkg::type_acr};
        else if (load_avi)
            m_header = {hdmi_packet_pkg::avi_length, hdmi_packet_pkg::avi_version,
                        hdmi_packet_pkg::type_avi};
        else if (request)
            m_header = {16'h0000, hdmi_packet_pkg::type_null};
        for (int i = 0; i < hdmi_packet_pkg::sub_count; i++)
        begin
            if (load_acr)
                m_sub[i] = acr_body(m_n, m_cts);
            else if (load_avi)
                m_sub[i] = (i == 0) ? avi_body(m_vic) : '0;
            else if (request)
                m_sub[i] = '0;
        end
        m_acr_pending = (m_acr_pending && !load_acr) || acr_strobe;
        m_avi_pending = (m_avi_pending && !load_avi) || (vsync && !m_vsync_prev);
        m_vsync_prev = vsync;
        if (acr_strobe)
        begin
            m_n = acr_n;
            m_cts = acr_cts;
        end
        m_vic = video_code;
        if (island_active)
            m_counter = m_counter + 1'b1;
    endtask

    task automatic drive_inputs();
        if (slot_left == 0 && gap_left == 0 && slots_started < slot_total)
        begin
            slot_left = hdmi_link_pkg::slot_cycles;
            gap_left = $unsigned($random(seed)) % (gap_max + 1);
            slots_started++;
        end
        island_active = slot_left > 0;
        if (slot_left > 0)
            slot_left--;
        else if (gap_left > 0)
            gap_left--;
        hsync = 1'($random(seed));
        if ($unsigned($random(seed)) % 128 == 0)
            vsync = ~vsync; // Rare edges leave room for null packets.
        acr_strobe = $unsigned($random(seed)) % 64 == 0;
        acr_n = 20'($random(seed));
        acr_cts = 20'($random(seed));
        video_code = 7'($random(seed));
    endtask

    task automatic check_slot();
        logic [7:0] sum;
        compare_header("header", rx_hblock[23:0], chk_header);
        compare_byte("header ecc", rx_hblock[31:24], parity_of({32'h0, chk_header}, 24));
        for (int i = 0; i < hdmi_packet_pkg::sub_count; i++)
        begin
            compare_sub($sformatf("sub%0d", i), rx_sblock[i][55:0], chk_sub[i]);
            compare_byte($sformatf("sub%0d ecc", i), rx_sblock[i][63:56],
                         parity_of(rx_sblock[i][55:0], 56));
        end
        case (rx_hblock[7:0])
            hdmi_packet_pkg::type_acr: acr_seen++;
            hdmi_packet_pkg::type_avi:
            begin
                // Header plus PB0 to PB13 must sum to zero.
                sum = rx_hblock[7:0] + rx_hblock[15:8] + rx_hblock[23:16];
                for (int b = 0; b < 7; b++)
                    sum = sum + rx_sblock[0][8*b +: 8] + rx_sblock[1][8*b +: 8];
                compare_byte("avi byte sum", sum, 8'h00);
                avi_seen++;
            end
            default: null_seen++;
        endcase
        checked_slots++;
    endtask

    task automatic check_slice();
        logic [4:0] d0;
        logic [4:0] d1;
        logic [4:0] d2;
        logic [3:0] exp_nibble;
        int k;
        k = int'(h1_k);
        if (k == 0)
        begin
            chk_header = m_header; // No new packet loads before slice 31.
            chk_sub = m_sub;
        end
        d0 = decode_terc4(tmds_ch0);
        d1 = decode_terc4(tmds_ch1);
        d2 = decode_terc4(tmds_ch2);
        if (!d0[4] || !d1[4] || !d2[4])
            fail_run($sformatf("Slice %0d carries a symbol that is not a TERC4 code.", k));
        // Packet start flag and the two syncs.
        // The header bit is checked with the whole header once the slot is complete.
        exp_nibble = {k != 0, d0[2], h1_vs, h1_hs};
        compare_symbol("tmds_ch0", tmds_ch0, hdmi_link_pkg::terc4_table[exp_nibble]);
        rx_hblock[k] = d0[2];
        for (int i = 0; i < hdmi_packet_pkg::sub_count; i++)
        begin
            rx_sblock[i][2*k] = d1[i];   // Even bits ride on channel 1.
            rx_sblock[i][2*k+1] = d2[i];
        end
        if (k == hdmi_link_pkg::slot_cycles - 1)
            check_slot();
    endtask

    task automatic step();
        @(negedge clk_pixel);
        if (h1_active)
            check_slice();
        drive_inputs();
        h1_active = h0_active;
        h1_k = h0_k;
        h1_hs = h0_hs;
        h1_vs = h0_vs;
        h0_active = island_active;
        h0_k = m_counter;
        h0_hs = hsync;
        h0_vs = vsync;
        model_step();
    endtask

    initial
    begin
        island_active = 1'b0;
        hsync = 1'b0;
        vsync = 1'b0;
        acr_strobe = 1'b0;
        acr_n = '0;
        acr_cts = '0;
        video_code = '0;
        m_counter = '0;
        m_acr_pending = 1'b0;
        m_avi_pending = 1'b0;
        m_vsync_prev = 1'b0;
        m_n = '0;
        m_cts = '0;
        m_vic = '0;
        m_header = {16'h0000, hdmi_packet_pkg::type_null};
        m_sub = '{default: '0};
        {h0_active, h1_active, h0_hs, h1_hs, h0_vs, h1_vs} = '0;
        h0_k = '0;
        h1_k = '0;
        wait (rst_n === 1'b1);
        while (slots_started < slot_total || slot_left > 0)
            step();
        repeat (3) step(); // Let the last slices leave the pipeline.
        $display("Slots checked: %0d, acr %0d, avi %0d, null %0d",
                 checked_slots, acr_seen, avi_seen, null_seen);
        if (checked_slots != slot_total)
            fail_run("Not every packet slot reached the checker.");
        else if (acr_seen == 0 || avi_seen == 0 || null_seen == 0)
            fail_run("The run did not carry every kind of packet.");
        else
        begin
            $display("*** PASSED ***");
            $finish;
        end
    end

    initial
    begin
        #(watchdog_ns);
        fail_run("Timeout: the run did not finish in the expected time.");
    end

endmodule

/* verilog/hdmi_data_island.sv */
`timescale 1ns/100ps

module hdmi_data_island (
    input  logic                                        clk_pixel,
    input  logic                                        rst_n,
    input  logic                                        island_active,
    input  logic                                        hsync,
    input  logic                                        vsync,
    input  logic                                        acr_strobe,
    input  logic [hdmi_packet_pkg::acr_field_width-1:0] acr_n,
    input  logic [hdmi_packet_pkg::acr_field_width-1:0] acr_cts,
    input  logic [hdmi_packet_pkg::vic_width-1:0]       video_code,
    output logic [hdmi_link_pkg::symbol_width-1:0]      tmds_ch0,
    output logic [hdmi_link_pkg::symbol_width-1:0]      tmds_ch1,
    output logic [hdmi_link_pkg::symbol_width-1:0]      tmds_ch2
);

    logic [hdmi_packet_pkg::header_width-1:0] acr_header, avi_header, header;
    logic [hdmi_packet_pkg::sub_width-1:0] acr_sub0, acr_sub1, acr_sub2, acr_sub3;
    logic [hdmi_packet_pkg::sub_width-1:0] avi_sub0, avi_sub1, avi_sub2, avi_sub3;
    logic [hdmi_packet_pkg::sub_width-1:0] sub0, sub1, sub2, sub3;
    logic [hdmi_link_pkg::data_width-1:0] packet_data;
    logic packet_first;
    logic packet_request;

    // Candidate packets, rebuilt whenever N, CTS or the video code change.
    infoframe_builder u_builder (
        .clk_pixel(clk_pixel), .rst_n(rst_n), .acr_strobe(acr_strobe),
        .acr_n(acr_n), .acr_cts(acr_cts), .video_code(video_code),
        .acr_header(acr_header), .acr_sub0(acr_sub0), .acr_sub1(acr_sub1),
        .acr_sub2(acr_sub2), .acr_sub3(acr_sub3),
        .avi_header(avi_header), .avi_sub0(avi_sub0), .avi_sub1(avi_sub1),
        .avi_sub2(avi_sub2), .avi_sub3(avi_sub3)
    );

    packet_picker u_picker (
        .clk_pixel(clk_pixel), .rst_n(rst_n), .packet_request(packet_request),
        .acr_strobe(acr_strobe), .vsync(vsync),
        .acr_header(acr_header), .acr_sub0(acr_sub0), .acr_sub1(acr_sub1),
        .acr_sub2(acr_sub2), .acr_sub3(acr_sub3),
        .avi_header(avi_header), .avi_sub0(avi_sub0), .avi_sub1(avi_sub1),
        .avi_sub2(avi_sub2), .avi_sub3(avi_sub3),
        .header(header), .sub0(sub0), .sub1(sub1), .sub2(sub2), .sub3(sub3)
    );

    // The outside scheduler hands over island_active in whole packet slots.
    packet_assembler u_assembler (
        .clk_pixel(clk_pixel), .rst_n(rst_n), .enable(island_active),
        .header(header), .sub0(sub0), .sub1(sub1), .sub2(sub2), .sub3(sub3),
        .packet_data(packet_data), .packet_first(packet_first),
        .packet_request(packet_request)
    );

    terc4_encoder u_encoder (
        .clk_pixel(clk_pixel), .rst_n(rst_n), .packet_data(packet_data),
        .packet_first(packet_first), .hsync(hsync), .vsync(vsync),
        .tmds_ch0(tmds_ch0), .tmds_ch1(tmds_ch1), .tmds_ch2(tmds_ch2)
    );

endmodule

/* verilog/infoframe_builder.sv */
`timescale 1ns/100ps

module infoframe_builder (
    input  logic                                        clk_pixel,
    input  logic                                        rst_n,
    input  logic                                        acr_strobe,
    input  logic [hdmi_packet_pkg::acr_field_width-1:0] acr_n,
    input  logic [hdmi_packet_pkg::acr_field_width-1:0] acr_cts,
    input  logic [hdmi_packet_pkg::vic_width-1:0]       video_code,
    output logic [hdmi_packet_pkg::header_width-1:0]    acr_header,
    output logic [hdmi_packet_pkg::sub_width-1:0]       acr_sub0,
    output logic [hdmi_packet_pkg::sub_width-1:0]       acr_sub1,
    output logic [hdmi_packet_pkg::sub_width-1:0]       acr_sub2,
    output logic [hdmi_packet_pkg::sub_width-1:0]       acr_sub3,
    output logic [hdmi_packet_pkg::header_width-1:0]    avi_header,
    output logic [hdmi_packet_pkg::sub_width-1:0]       avi_sub0,
    output logic [hdmi_packet_pkg::sub_width-1:0]       avi_sub1,
    output logic [hdmi_packet_pkg::sub_width-1:0]       avi_sub2,
    output logic [hdmi_packet_pkg::sub_width-1:0]       avi_sub3
);

    logic [hdmi_packet_pkg::acr_field_width-1:0] n_reg;
    logic [hdmi_packet_pkg::acr_field_width-1:0] cts_reg;
    logic [hdmi_packet_pkg::vic_width-1:0] vic_reg;
    logic [hdmi_packet_pkg::sub_width-1:0] acr_word;
    logic [7:0] avi_pb4;      // Video identification code byte.
    logic [7:0] avi_sum;      // Sum of all nonzero bytes other than the checksum.
    logic [7:0] avi_checksum;

    always_ff @(posedge clk_pixel)
    begin
        if (!rst_n)
        begin
            n_reg <= '0;
            cts_reg <= '0;
            vic_reg <= '0;
        end
        else
        begin
            if (acr_strobe)
            begin
                n_reg <= acr_n;     // N and CTS always arrive as a pair.
                cts_reg <= acr_cts;
            end
            vic_reg <= video_code;
        end
    end

    // ACR header is type only; HB1 and HB2 are zero.
    assign acr_header = {8'h00, 8'h00, hdmi_packet_pkg::type_acr};
    // SB0 is zero, SB1 to SB3 hold CTS and SB4 to SB6 hold N, high byte first.
    assign acr_word = {n_reg[7:0], n_reg[15:8], 4'h0, n_reg[19:16],
                       cts_reg[7:0], cts_reg[15:8], 4'h0, cts_reg[19:16], 8'h00};
    assign acr_sub0 = acr_word; // The same regeneration values fill all four.
    assign acr_sub1 = acr_word;
    assign acr_sub2 = acr_word;
    assign acr_sub3 = acr_word;

    assign avi_header = {hdmi_packet_pkg::avi_length, hdmi_packet_pkg::avi_version,
                         hdmi_packet_pkg::type_avi};
    assign avi_pb4 = {1'b0, vic_reg};
    // PB1 selects RGB, PB2 carries aspect "same as picture" (8'h08).
    assign avi_sum = hdmi_packet_pkg::type_avi + hdmi_packet_pkg::avi_version
                   + hdmi_packet_pkg::avi_length + 8'h08 + avi_pb4;
    assign avi_checksum = 8'h00 - avi_sum; // All bytes then sum to zero.
    assign avi_sub0 = {8'h00, 8'h00, avi_pb4, 8'h00, 8'h08, 8'h00, avi_checksum};
    assign avi_sub1 = '0; // PB7 to PB13 carry no bar info.
    assign avi_sub2 = '0;
    assign avi_sub3 = '0;

endmodule

/* verilog/packet_picker.sv */
`timescale 1ns/100ps

module packet_picker (
    input  logic                                     clk_pixel,
    input  logic                                     rst_n,
    input  logic                                     packet_request,
    input  logic                                     acr_strobe,
    input  logic                                     vsync,
    input  logic [hdmi_packet_pkg::header_width-1:0] acr_header,
    input  logic [hdmi_packet_pkg::sub_width-1:0]    acr_sub0,
    input  logic [hdmi_packet_pkg::sub_width-1:0]    acr_sub1,
    input  logic [hdmi_packet_pkg::sub_width-1:0]    acr_sub2,
    input  logic [hdmi_packet_pkg::sub_width-1:0]    acr_sub3,
    input  logic [hdmi_packet_pkg::header_width-1:0] avi_header,
    input  logic [hdmi_packet_pkg::sub_width-1:0]    avi_sub0,
    input  logic [hdmi_packet_pkg::sub_width-1:0]    avi_sub1,
    input  logic [hdmi_packet_pkg::sub_width-1:0]    avi_sub2,
    input  logic [hdmi_packet_pkg::sub_width-1:0]    avi_sub3,
    output logic [hdmi_packet_pkg::header_width-1:0] header,
    output logic [hdmi_packet_pkg::sub_width-1:0]    sub0,
    output logic [hdmi_packet_pkg::sub_width-1:0]    sub1,
    output logic [hdmi_packet_pkg::sub_width-1:0]    sub2,
    output logic [hdmi_packet_pkg::sub_width-1:0]    sub3
);

    logic vsync_d;     // Previous vsync, for the rising edge.
    logic acr_pending;
    logic avi_pending;
    logic load_acr;
    logic load_avi;

    // ACR wins over AVI; a request with nothing pending sends a null packet.
    assign load_acr = packet_request && acr_pending;
    assign load_avi = packet_request && !acr_pending && avi_pending;

    always_ff @(posedge clk_pixel)
    begin
        if (!rst_n)
        begin
            vsync_d <= 1'b0;
            acr_pending <= 1'b0;
            avi_pending <= 1'b0;
            header <= {16'h0000, hdmi_packet_pkg::type_null}; // Null until the first request.
            {sub0, sub1, sub2, sub3} <= '0;
        end
        else
        begin
            vsync_d <= vsync;
            // A new event in the load cycle keeps its flag for the next slot.
            acr_pending <= (acr_pending && !load_acr) || acr_strobe;
            avi_pending <= (avi_pending && !load_avi) || (vsync && !vsync_d);
            if (load_acr)
                {header, sub0, sub1, sub2, sub3} <=
                    {acr_header, acr_sub0, acr_sub1, acr_sub2, acr_sub3};
            else if (load_avi)
                {header, sub0, sub1, sub2, sub3} <=
                    {avi_header, avi_sub0, avi_sub1, avi_sub2, avi_sub3};
            else if (packet_request)
            begin
                header <= {16'h0000, hdmi_packet_pkg::type_null};
                {sub0, sub1, sub2, sub3} <= '0;
            end
        end
    end

endmodule

/* verilog/terc4_encoder.sv */
`timescale 1ns/100ps

module terc4_encoder (
    input  logic                                     clk_pixel,
    input  logic                                     rst_n,
    input  logic [hdmi_link_pkg::data_width-1:0]     packet_data,
    input  logic                                     packet_first,
    input  logic                                     hsync,
    input  logic                                     vsync,
    output logic [hdmi_link_pkg::symbol_width-1:0]   tmds_ch0,
    output logic [hdmi_link_pkg::symbol_width-1:0]   tmds_ch1,
    output logic [hdmi_link_pkg::symbol_width-1:0]   tmds_ch2
);

    logic hsync_d; // First sync stage, level with packet_data.
    logic vsync_d;
    logic [hdmi_link_pkg::nibble_width-1:0] ch0_nibble;

    // Bit 3 drops only in the first slice of a packet.
    // Bit 2 is the header bit and bits 1:0 carry the syncs.
    assign ch0_nibble = {~packet_first, packet_data[0], vsync_d, hsync_d};

    always_ff @(posedge clk_pixel)
    begin
        if (!rst_n)
        begin
            hsync_d <= 1'b0;
            vsync_d <= 1'b0;
        end
        else
        begin
            hsync_d <= hsync; // Matches the assembler's one-cycle latency.
            vsync_d <= vsync;
        end
    end

    // Second stage, so the syncs leave two cycles after they arrive.
    always_ff @(posedge clk_pixel)
    begin
        tmds_ch0 <= hdmi_link_pkg::terc4_table[ch0_nibble];
        tmds_ch1 <= hdmi_link_pkg::terc4_table[packet_data[4:1]]; // Even bits.
        tmds_ch2 <= hdmi_link_pkg::terc4_table[packet_data[8:5]]; // Odd bits.
    end

endmodule
